/* all.f */
source/fetch_pkg.sv
source/pc_gen.sv
source/cache_way.sv
source/icache_resp.sv
source/fetch_top.sv
test/fetch_assert.sv
test/fetch_tb.sv

/* run.sh */
#!/bin/bash
verilator --binary --timing --assert -f all.f --top-module fetch_tb -o fetch_sim > build.log 2>&1 \
  && ./obj_dir/fetch_sim > sim.log 2>&1 ; \
  grep -qx "STATUS: PASS" sim.log && echo "simulation passed" \
  || { echo "simulation failed, see build.log and sim.log"; exit 1; }

/* source/cache_way.sv */
module cache_way #(
  parameter int NUM_SETS   = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  fetch_pkg::fetch_req_t lookup_i,
  input  logic                  hold_i,
  input  fetch_pkg::refill_t    refill_i,
  input  logic                  we_i,
  output logic                  hit_o,
  output fetch_pkg::bus_word_u  word_o
);

  localparam int OFF_W   = $clog2(LINE_WORDS);
  localparam int IDX_W   = $clog2(NUM_SETS);
  localparam int IDX_LSB = OFF_W + 3;           // 8 byte words
  localparam int TAG_LSB = IDX_LSB + IDX_W;
  localparam int TAG_W   = fetch_pkg::ADDR_W - TAG_LSB;

  logic [NUM_SETS-1:0]  valid_q;
  logic [TAG_W-1:0]     tag_mem [NUM_SETS];
  fetch_pkg::bus_word_u data_mem [NUM_SETS][LINE_WORDS];

  fetch_pkg::fetch_req_t held_q;                // lookup behind hit_o/word_o
  fetch_pkg::fetch_req_t rd_req;
  logic [IDX_W-1:0]      rd_idx;
  logic [OFF_W-1:0]      rd_off;
  logic [TAG_W-1:0]      rd_tag;
  logic                  wr_en;
  logic [IDX_W-1:0]      wr_idx;
  logic [OFF_W-1:0]      wr_off;
  logic [TAG_W-1:0]      wr_tag;

  // while held the same lookup is compared again each cycle,
  // so a completed refill turns the held miss into a hit
  assign rd_req = hold_i ? held_q : lookup_i;
  assign rd_idx = rd_req.addr[IDX_LSB +: IDX_W];
  assign rd_off = rd_req.addr[3 +: OFF_W];
  assign rd_tag = rd_req.addr[TAG_LSB +: TAG_W];

  assign wr_en  = we_i & refill_i.valid;
  assign wr_idx = refill_i.idx[IDX_W-1:0];
  assign wr_off = refill_i.off[OFF_W-1:0];
  assign wr_tag = refill_i.tag[TAG_W-1:0];

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q <= '0;
      held_q  <= '0;
      hit_o   <= 1'b0;
    end else begin
      held_q <= rd_req;
      hit_o  <= rd_req.valid & valid_q[rd_idx] & (tag_mem[rd_idx] == rd_tag);
      if (wr_en) begin
        valid_q[wr_idx] <= refill_i.last;       // partial line is never valid
      end
    end
  end

  // arrays and registered read
  always_ff @(posedge clk) begin
    word_o <= data_mem[rd_idx][rd_off];
    if (wr_en) begin
      data_mem[wr_idx][wr_off] <= refill_i.data;
      if (refill_i.last) begin
        tag_mem[wr_idx] <= wr_tag;
      end
    end
  end

endmodule

/* source/fetch_pkg.sv */
package fetch_pkg;

  localparam int ADDR_W  = 32;
  localparam int INSTR_W = 32;
  localparam int BUS_W   = 64;                  // axi data and cache word

  // refill index and offset cover up to 256 sets of 16 words
  localparam int MAX_IDX_W = 8;
  localparam int MAX_OFF_W = 4;
  localparam int MAX_TAG_W = ADDR_W - 3;        // wide enough for any index/offset split

  localparam logic [2:0] AXI_SIZE_8B    = 3'b011;
  localparam logic [1:0] AXI_BURST_INCR = 2'b01;

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [INSTR_W-1:0] instr_t;

  // one bus beat, stored raw and read back as two instructions
  typedef union packed {
    logic [BUS_W-1:0] raw;
    instr_t [1:0]     half;                     // picked by addr bit 2
  } bus_word_u;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } fetch_req_t;

  // one refill beat into the way arrays
  typedef struct packed {
    logic                 valid;
    logic [MAX_IDX_W-1:0] idx;                  // low bits used
    logic [MAX_TAG_W-1:0] tag;                  // low bits used
    logic [MAX_OFF_W-1:0] off;
    bus_word_u            data;
    logic                 last;                 // line complete after this beat
  } refill_t;

  // axi read address channel, refill subset
  typedef struct packed {
    logic       valid;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } axi_ar_t;

  // axi read data channel
  typedef struct packed {
    logic       valid;
    bus_word_u  data;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

endpackage

/* source/fetch_top.sv */
module fetch_top #(
  parameter int               NUM_WAYS   = 2,             // power of two
  parameter int               NUM_SETS   = 16,
  parameter int               LINE_WORDS = 4,             // bus words per line
  parameter fetch_pkg::addr_t RESET_PC   = 32'h8000_0000
) (
  input  logic               clk,
  input  logic               arst_n_i,
  input  logic               redirect_valid_i,
  input  fetch_pkg::addr_t   redirect_pc_i,
  output logic               instr_valid_o,
  output fetch_pkg::instr_t  instr_o,
  output fetch_pkg::addr_t   instr_pc_o,
  input  logic               instr_ready_i,
  output fetch_pkg::axi_ar_t axi_ar_o,
  input  logic               axi_ar_ready_i,
  input  fetch_pkg::axi_r_t  axi_r_i,
  output logic               axi_r_ready_o
);

  fetch_pkg::fetch_req_t lookup;
  logic                  hold;
  fetch_pkg::refill_t    refill;
  logic [NUM_WAYS-1:0]   way_we;
  logic [NUM_WAYS-1:0]   way_hit;
  fetch_pkg::bus_word_u  way_word [NUM_WAYS];

  pc_gen #(
    .RESET_PC (RESET_PC)
  ) pc_gen_u (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .hold_i           (hold),
    .lookup_o         (lookup)
  );

  for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
    cache_way #(
      .NUM_SETS   (NUM_SETS),
      .LINE_WORDS (LINE_WORDS)
    ) cache_way_u (
      .clk      (clk),
      .arst_n_i (arst_n_i),
      .lookup_i (lookup),
      .hold_i   (hold),
      .refill_i (refill),
      .we_i     (way_we[w]),
      .hit_o    (way_hit[w]),
      .word_o   (way_word[w])
    );
  end

  icache_resp #(
    .NUM_WAYS   (NUM_WAYS),
    .NUM_SETS   (NUM_SETS),
    .LINE_WORDS (LINE_WORDS)
  ) icache_resp_u (
    .clk              (clk),
    .arst_n_i         (arst_n_i),
    .lookup_i         (lookup),
    .redirect_valid_i (redirect_valid_i),
    .way_hit_i        (way_hit),
    .way_word_i       (way_word),
    .instr_ready_i    (instr_ready_i),
    .hold_o           (hold),
    .refill_o         (refill),
    .way_we_o         (way_we),
    .instr_valid_o    (instr_valid_o),
    .instr_o          (instr_o),
    .instr_pc_o       (instr_pc_o),
    .axi_ar_o         (axi_ar_o),
    .axi_ar_ready_i   (axi_ar_ready_i),
    .axi_r_i          (axi_r_i),
    .axi_r_ready_o    (axi_r_ready_o)
  );

endmodule

/* source/icache_resp.sv */
module icache_resp #(
  parameter int NUM_WAYS   = 2,
  parameter int NUM_SETS   = 16,
  parameter int LINE_WORDS = 4
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  fetch_pkg::fetch_req_t lookup_i,
  input  logic                  redirect_valid_i,
  input  logic [NUM_WAYS-1:0]   way_hit_i,
  input  fetch_pkg::bus_word_u  way_word_i [NUM_WAYS],
  input  logic                  instr_ready_i,
  output logic                  hold_o,
  output fetch_pkg::refill_t    refill_o,
  output logic [NUM_WAYS-1:0]   way_we_o,
  output logic                  instr_valid_o,
  output fetch_pkg::instr_t     instr_o,
  output fetch_pkg::addr_t      instr_pc_o,
  output fetch_pkg::axi_ar_t    axi_ar_o,
  input  logic                  axi_ar_ready_i,
  input  fetch_pkg::axi_r_t     axi_r_i,
  output logic                  axi_r_ready_o
);

  localparam int OFF_W   = $clog2(LINE_WORDS);
  localparam int IDX_W   = $clog2(NUM_SETS);
  localparam int IDX_LSB = OFF_W + 3;
  localparam int TAG_LSB = IDX_LSB + IDX_W;
  localparam int TAG_W   = fetch_pkg::ADDR_W - TAG_LSB;
  localparam int WAY_W   = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

  typedef enum logic [1:0] {
    IDLE,
    AR_REQ,    // address out, waiting for ready
    R_DATA,    // beats streaming into the victim
    REPLAY     // ways re-read the held lookup
  } state_e;

  state_e               state_q, state_d;
  logic                 req_q;        // lookup in flight is still wanted
  fetch_pkg::addr_t     pc_q;
  logic                 hit_any;
  fetch_pkg::bus_word_u hit_word;
  logic                 miss_seen;
  logic                 beat_fire;
  logic [OFF_W-1:0]     beat_q;
  logic [WAY_W-1:0]     victim_q;     // global round robin

  // merge the ways, at most one hits
  always_comb begin
    hit_word = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_hit_i[w]) begin
        hit_word.raw = hit_word.raw | way_word_i[w].raw;
      end
    end
  end

  assign hit_any   = |way_hit_i;
  assign miss_seen = (state_q == IDLE) & req_q & ~hit_any;

  assign instr_valid_o = (state_q == IDLE) & req_q & hit_any;
  assign instr_o       = hit_word.half[pc_q[2]];
  assign instr_pc_o    = pc_q;

  // stall on back-pressure and for the whole miss
  assign hold_o = (state_q != IDLE) | miss_seen | (instr_valid_o & ~instr_ready_i);

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      req_q <= 1'b0;
    end else if (redirect_valid_i) begin
      req_q <= 1'b0;                          // drop pending output or replay
    end else if (!hold_o) begin
      req_q <= lookup_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!hold_o) begin
      pc_q <= lookup_i.addr;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (miss_seen && !redirect_valid_i) state_d = AR_REQ;
      AR_REQ:  if (axi_ar_ready_i) state_d = R_DATA;
      R_DATA:  if (axi_r_i.valid && axi_r_i.last) state_d = REPLAY;
      default: state_d = IDLE;                // refreshed way outputs are valid now
    endcase
  end

  assign beat_fire = (state_q == R_DATA) & axi_r_i.valid;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q  <= IDLE;
      beat_q   <= '0;
      victim_q <= '0;
    end else begin
      state_q <= state_d;
      if (state_q == AR_REQ) begin
        beat_q <= '0;
      end else if (beat_fire) begin
        beat_q <= beat_q + 1'b1;
      end
      if (beat_fire && axi_r_i.last) begin
        if (victim_q == WAY_W'(NUM_WAYS - 1)) begin
          victim_q <= '0;
        end else begin
          victim_q <= victim_q + 1'b1;
        end
      end
    end
  end

  // refill beat shared by all ways, only the victim is enabled
  always_comb begin
    refill_o                 = '0;
    refill_o.valid           = beat_fire;
    refill_o.idx[IDX_W-1:0]  = pc_q[IDX_LSB +: IDX_W];
    refill_o.tag[TAG_W-1:0]  = pc_q[TAG_LSB +: TAG_W];
    refill_o.off[OFF_W-1:0]  = beat_q;
    refill_o.data            = axi_r_i.data;
    refill_o.last            = axi_r_i.last;
    way_we_o                 = '0;
    if (beat_fire) begin
      way_we_o[victim_q] = 1'b1;
    end
  end

  // pc_q is frozen by hold so the fields stay put until ready
  assign axi_ar_o.valid = (state_q == AR_REQ);
  assign axi_ar_o.addr  = {pc_q[fetch_pkg::ADDR_W-1:IDX_LSB], {IDX_LSB{1'b0}}};
  assign axi_ar_o.len   = 8'(LINE_WORDS - 1);
  assign axi_ar_o.size  = fetch_pkg::AXI_SIZE_8B;
  assign axi_ar_o.burst = fetch_pkg::AXI_BURST_INCR;

  assign axi_r_ready_o = (state_q == R_DATA);

endmodule

/* source/pc_gen.sv */
module pc_gen #(
  parameter fetch_pkg::addr_t RESET_PC = 32'h8000_0000
) (
  input  logic                  clk,
  input  logic                  arst_n_i,
  input  logic                  redirect_valid_i,
  input  fetch_pkg::addr_t      redirect_pc_i,
  input  logic                  hold_i,
  output fetch_pkg::fetch_req_t lookup_o
);

  fetch_pkg::addr_t pc_q;   // pc of the lookup presented this cycle
  logic             run_q;  // first lookup goes out one cycle after reset
  logic             issue;

  // a lookup is taken by the ways whenever it is presented and not held
  assign issue = run_q & ~hold_i;

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_q  <= RESET_PC;
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (redirect_valid_i) begin
        // redirect wins over hold, the pending lookup is dropped downstream
        pc_q <= {redirect_pc_i[fetch_pkg::ADDR_W-1:2], 2'b00};
      end else if (issue) begin
        pc_q <= pc_q + fetch_pkg::ADDR_W'(4);  // next sequential instruction
      end
    end
  end

  assign lookup_o.valid = run_q;
  assign lookup_o.addr  = pc_q;

endmodule

/* test/fetch_assert.sv */
module fetch_assert #(
  parameter int               LINE_WORDS = 4,
  parameter fetch_pkg::addr_t RESET_PC   = 32'h8000_0000
) (
  input logic               clk,
  input logic               arst_n_i,
  input logic               redirect_valid_i,
  input fetch_pkg::addr_t   redirect_pc_i,
  input logic               instr_valid_o,
  input fetch_pkg::instr_t  instr_o,
  input fetch_pkg::addr_t   instr_pc_o,
  input logic               instr_ready_i,
  input fetch_pkg::axi_ar_t axi_ar_o,
  input logic               axi_ar_ready_i,
  input fetch_pkg::axi_r_t  axi_r_i,
  input logic               axi_r_ready_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam fetch_pkg::addr_t LINE_MASK = fetch_pkg::addr_t'(LINE_WORDS * 8 - 1);
  localparam fetch_pkg::instr_t MEM_KEY  = 32'h5A5A_5A5A;

  fetch_pkg::addr_t exp_pc;      // pc the next delivery must carry
  logic             burst_open;  // ar accepted, last beat not yet seen

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_pc     <= RESET_PC;
      burst_open <= 1'b0;
    end else begin
      if (redirect_valid_i) begin
        exp_pc <= {redirect_pc_i[fetch_pkg::ADDR_W-1:2], 2'b00};
      end else if (instr_valid_o && instr_ready_i) begin
        exp_pc <= exp_pc + fetch_pkg::addr_t'(4);
      end
      if (axi_ar_o.valid && axi_ar_ready_i) begin
        burst_open <= 1'b1;
      end else if (axi_r_i.valid && axi_r_ready_o && axi_r_i.last) begin
        burst_open <= 1'b0;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) !arst_n_i |-> !instr_valid_o && !axi_ar_o.valid)
    else $error("instruction or read address valid while in reset");
  a_seq_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
    instr_valid_o |-> instr_pc_o == exp_pc)
    else $error("mismatch seq_pc: expected %h, actual %h",
                $sampled(exp_pc), $sampled(instr_pc_o));
  a_mem_data: assert property (@(posedge clk) disable iff (!arst_n_i)
    instr_valid_o |-> instr_o == (instr_pc_o ^ MEM_KEY))
    else $error("mismatch mem_data: expected %h, actual %h",
                $sampled(instr_pc_o) ^ MEM_KEY, $sampled(instr_o));
  a_out_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    instr_valid_o && !instr_ready_i && !redirect_valid_i |=>
      instr_valid_o && $stable(instr_o) && $stable(instr_pc_o))
    else $error("instruction output changed under back-pressure");
  a_ar_fields: assert property (@(posedge clk) disable iff (!arst_n_i)
    axi_ar_o.valid |-> (axi_ar_o.addr & LINE_MASK) == '0 && axi_ar_o.len == 8'(LINE_WORDS - 1)
      && axi_ar_o.size == fetch_pkg::AXI_SIZE_8B && axi_ar_o.burst == fetch_pkg::AXI_BURST_INCR)
    else $error("read address not a line burst");
  a_ar_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
    axi_ar_o.valid && !axi_ar_ready_i |=> axi_ar_o.valid && $stable(axi_ar_o))
    else $error("read address dropped or changed before ready");
  a_one_burst: assert property (@(posedge clk) disable iff (!arst_n_i)
    axi_ar_o.valid |-> !burst_open)
    else $error("second read address before the last beat");
  a_r_ready: assert property (@(posedge clk) disable iff (!arst_n_i)
    burst_open |-> axi_r_ready_o)
    else $error("read data not ready during a burst");

endmodule

bind fetch_top fetch_assert #(
  .LINE_WORDS (LINE_WORDS),
  .RESET_PC   (RESET_PC)
) fetch_assert_u (
  .clk              (clk),
  .arst_n_i         (arst_n_i),
  .redirect_valid_i (redirect_valid_i),
  .redirect_pc_i    (redirect_pc_i),
  .instr_valid_o    (instr_valid_o),
  .instr_o          (instr_o),
  .instr_pc_o       (instr_pc_o),
  .instr_ready_i    (instr_ready_i),
  .axi_ar_o         (axi_ar_o),
  .axi_ar_ready_i   (axi_ar_ready_i),
  .axi_r_i          (axi_r_i),
  .axi_r_ready_o    (axi_r_ready_o)
);

/* test/fetch_tb.sv */
module fetch_tb;
  timeunit 1ns;
  timeprecision 1ps;

  // about 200 instructions of 12 cycle misses plus random stalls and margin
  localparam int CYCLE_LIMIT = 4000;
  localparam int NUM_SETS    = 16;
  localparam int NUM_WAYS    = 2;
  localparam int LINE_BYTES  = 32;
  localparam fetch_pkg::addr_t  RESET_PC = 32'h8000_0000;
  localparam fetch_pkg::instr_t MEM_KEY  = 32'h5A5A_5A5A;
  localparam fetch_pkg::addr_t  EVICT_PC = 32'h8000_1100;   // set 8

  logic clk, arst_n_i, redirect_valid_i, instr_valid_o, instr_ready_i;
  logic axi_ar_ready_i, axi_r_ready_o;
  fetch_pkg::addr_t   redirect_pc_i, instr_pc_o;
  fetch_pkg::instr_t  instr_o;
  fetch_pkg::axi_ar_t axi_ar_o;
  fetch_pkg::axi_r_t  axi_r_i;

  int cycles = 0, errors = 0, tests_run = 0, tests_failed = 0;
  int ready_mode = 1;                  // 0 stop, 1 always, 2 random
  int stall_cycles = 0, ar_count = 0, redir_idx = 0, victim = 0;
  bit redir_pend = 0, parked = 0, burst_busy = 0, got_ar;
  fetch_pkg::addr_t  redir_pc, deliv_pc[$];
  fetch_pkg::instr_t deliv_instr[$];
  fetch_pkg::addr_t  res_line [NUM_SETS][NUM_WAYS];   // residency model
  bit                res_valid [NUM_SETS][NUM_WAYS];

  fetch_top dut_i (.*);

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic int set_of(fetch_pkg::addr_t a);
    return int'((a / fetch_pkg::addr_t'(LINE_BYTES)) % fetch_pkg::addr_t'(NUM_SETS));
  endfunction

  function automatic bit is_resident(fetch_pkg::addr_t a);
    fetch_pkg::addr_t line;
    line = a & ~fetch_pkg::addr_t'(LINE_BYTES - 1);
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (res_valid[set_of(a)][w] && res_line[set_of(a)][w] == line) return 1'b1;
    end
    return 1'b0;
  endfunction

  // drive fetch inputs and log the transfer taken at the coming rising edge
  always @(negedge clk) begin
    if (ready_mode == 0) instr_ready_i = 1'b0;
    else if (ready_mode == 1) instr_ready_i = 1'b1;
    else instr_ready_i = ($urandom % 3) != 0;
    parked = arst_n_i && instr_valid_o && !instr_ready_i;
    if (parked) stall_cycles++;
    if (arst_n_i && instr_valid_o && instr_ready_i) begin
      deliv_pc.push_back(instr_pc_o);
      deliv_instr.push_back(instr_o);
    end
    redirect_valid_i = redir_pend;
    if (redir_pend) begin
      redirect_pc_i = redir_pc;
      redir_idx     = deliv_pc.size();  // first delivery after the pulse
      redir_pend    = 1'b0;
    end
  end

  // axi memory model with random ready and beat gaps
  initial begin
    fetch_pkg::addr_t a;
    int len;
    forever begin
      @(negedge clk);
      if (arst_n_i && axi_ar_o.valid) begin
        a   = axi_ar_o.addr;
        len = int'(axi_ar_o.len);
        repeat ($urandom % 3) @(negedge clk);
        axi_ar_ready_i = 1'b1;
        ar_count++;
        burst_busy = 1'b1;
        @(negedge clk);
        axi_ar_ready_i = 1'b0;
        for (int b = 0; b <= len; b++) begin
          repeat ($urandom % 3) @(negedge clk);
          axi_r_i.valid          = 1'b1;
          axi_r_i.data.half[0]   = (a + fetch_pkg::addr_t'(8 * b)) ^ MEM_KEY;
          axi_r_i.data.half[1]   = (a + fetch_pkg::addr_t'(8 * b + 4)) ^ MEM_KEY;
          axi_r_i.last           = (b == len);
          @(negedge clk);
          axi_r_i.valid = 1'b0;
          axi_r_i.last  = 1'b0;
        end
        res_line[set_of(a)][victim]  = a;    // same global round robin
        res_valid[set_of(a)][victim] = 1'b1;
        victim     = (victim + 1) % NUM_WAYS;
        burst_busy = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      errors++;
      $display("mismatch %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_true(input string name, input bit cond, input string what);
    if (!cond) begin
      errors++;
      $display("%s: %s", name, what);
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic wait_deliveries(input int n);
    while (deliv_pc.size() < n) @(posedge clk);
  endtask

  task automatic redirect_to(input fetch_pkg::addr_t pc);
    @(posedge clk);
    redir_pc   = pc;
    redir_pend = 1'b1;
    while (redir_pend) @(posedge clk);
  endtask

  task automatic park_output;
    ready_mode = 0;
    repeat (2) @(posedge clk);
    while (!parked) @(posedge clk);
  endtask

  // redirect from a parked output and compare refill traffic with the model
  task automatic redirect_and_check(input fetch_pkg::addr_t target, output bit saw_ar);
    bit want_ar;
    int ar_before;
    park_output();
    want_ar   = !is_resident(target);
    ar_before = ar_count;
    redirect_to(target);
    ready_mode = 1;
    wait_deliveries(redir_idx + 1);
    saw_ar = ar_count != ar_before;
    check_value("hits_replacement", target, deliv_pc[redir_idx]);
    check_true("hits_replacement", saw_ar == want_ar,
               want_ar ? "expected refill was not issued" : "resident line was refilled");
  endtask

  initial begin
    int e;
    fetch_pkg::addr_t exp_pc;
    void'($urandom(8738));
    arst_n_i         = 1'b0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    instr_ready_i    = 1'b1;
    axi_ar_ready_i   = 1'b0;
    axi_r_i          = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n_i = 1'b1;

    e = errors;
    check_true("reset_first_fetch", !instr_valid_o && !axi_ar_o.valid, "outputs active after reset");
    wait_deliveries(1);
    check_value("reset_first_fetch", RESET_PC, deliv_pc[0]);
    check_value("reset_first_fetch", RESET_PC ^ MEM_KEY, deliv_instr[0]);
    end_test("reset_first_fetch", e);

    e = errors;
    wait_deliveries(41);
    for (int i = 1; i < 41; i++) begin
      exp_pc = RESET_PC + fetch_pkg::addr_t'(4 * i);
      check_value("sequential_stream", exp_pc, deliv_pc[i]);
      check_value("sequential_stream", exp_pc ^ MEM_KEY, deliv_instr[i]);
    end
    end_test("sequential_stream", e);

    e = errors;
    check_true("axi_refill", ar_count >= 6, "fewer refills than lines streamed");
    end_test("axi_refill", e);

    e = errors;
    redirect_and_check(RESET_PC, got_ar);
    redirect_and_check(RESET_PC + 32'h20, got_ar);
    for (int k = 0; k < 3; k++) begin
      redirect_and_check(EVICT_PC + fetch_pkg::addr_t'(k * 'h200), got_ar);
    end
    redirect_and_check(EVICT_PC, got_ar);
    check_true("hits_replacement", got_ar, "evicted line was delivered without a refill");
    end_test("hits_replacement", e);

    e = errors;
    ready_mode = 2;
    stall_cycles = 0;
    wait_deliveries(deliv_pc.size() + 60);
    check_true("back_pressure", stall_cycles > 0, "no stall with valid output was reached");
    end_test("back_pressure", e);

    e = errors;
    redirect_to(32'h8000_3000);
    while (!burst_busy) @(posedge clk);
    redirect_to(32'h8000_2010);       // lands during the refill
    wait_deliveries(redir_idx + 1);
    check_value("redirect", 32'h8000_2010, deliv_pc[redir_idx]);
    check_value("redirect", 32'h8000_2010 ^ MEM_KEY, deliv_instr[redir_idx]);
    repeat (5) @(posedge clk);
    redirect_to(32'h8000_0044);
    wait_deliveries(redir_idx + 1);
    check_value("redirect", 32'h8000_0044, deliv_pc[redir_idx]);
    end_test("redirect", e);

    ready_mode = 1;
    repeat (10) @(posedge clk);
    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
